// File: logic/swu_pkg.sv
package swu_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // stream word format
   ////////////////////////////////////////////////////////////////////////////

   // channels carried side by side in one word
   localparam int SIMD         = 4;
   // bits per channel
   localparam int IP_PRECISION = 4;
   localparam int WORD_W       = SIMD * IP_PRECISION;

   ////////////////////////////////////////////////////////////////////////////
   // default geometry
   ////////////////////////////////////////////////////////////////////////////

   // square input feature map, one side
   localparam int DEF_IFM_DIM    = 7;
   // square kernel, one side
   localparam int DEF_KERNEL_DIM = 3;
   localparam int DEF_STRIDE     = 2;
   // words per pixel
   localparam int DEF_CH_GROUPS  = 2;
   // line buffer holds 2**DEF_BUF_AW words
   localparam int DEF_BUF_AW     = 6;

   // absolute word index inside one frame
   localparam int IDX_W = 16;

   ////////////////////////////////////////////////////////////////////////////
   // types
   ////////////////////////////////////////////////////////////////////////////

   typedef logic [WORD_W-1:0] word_t;

   // write into the line buffer, only the low address bits select the entry
   typedef struct packed {
      logic             en;
      logic [IDX_W-1:0] addr;
      word_t            data;
   } buf_wr_t;

   // read request from the window walker
   typedef struct packed {
      logic             en;
      logic [IDX_W-1:0] addr;
   } buf_rd_t;

endpackage

// File: logic/swu_write_ctrl.sv
`timescale 1ns/1ps

module swu_write_ctrl #(
   parameter int IFM_DIM   = swu_pkg::DEF_IFM_DIM,
   parameter int CH_GROUPS = swu_pkg::DEF_CH_GROUPS,
   parameter int BUF_AW    = swu_pkg::DEF_BUF_AW
) (
   input  logic                      clk,
   input  logic                      resetn,
   input  swu_pkg::word_t            ip_tdata_i,
   input  logic                      ip_tvalid_i,
   output logic                      ip_tready_o,
   input  logic [swu_pkg::IDX_W-1:0] window_origin_i,
   input  logic                      frame_done_i,
   output swu_pkg::buf_wr_t          wr_o,
   output logic [swu_pkg::IDX_W-1:0] words_written_o
);
   import swu_pkg::*;

   localparam logic [IDX_W-1:0] FRAME_WORDS = IDX_W'(IFM_DIM * IFM_DIM * CH_GROUPS);
   localparam logic [IDX_W-1:0] DEPTH       = IDX_W'(2 ** BUF_AW);

   logic [IDX_W-1:0] count_q;
   logic [IDX_W-1:0] ahead;
   logic             below_frame;
   logic             has_space;
   logic             accept;

   // words stored beyond the first word the current window still needs
   assign ahead = count_q - window_origin_i;

   assign below_frame = count_q < FRAME_WORDS;

   // a new word lands on entry count_q - DEPTH, which must already be behind
   // the window origin. origin can run ahead of the writer for stride > kernel
   assign has_space = (count_q < window_origin_i) || (ahead < DEPTH);

   assign ip_tready_o = below_frame && has_space;
   assign accept      = ip_tvalid_i && ip_tready_o;

   always_comb begin
      wr_o.en   = accept;
      wr_o.addr = count_q;
      wr_o.data = ip_tdata_i;
   end

   // absolute write index, restarts once the walker finishes the frame
   always_ff @(posedge clk) begin
      if (!resetn) begin
         count_q <= '0;
      end else if (frame_done_i) begin
         count_q <= '0;
      end else if (accept) begin
         count_q <= count_q + 1'b1;
      end
   end

   assign words_written_o = count_q;

endmodule

// File: logic/swu_line_buffer.sv
`timescale 1ns/1ps

module swu_line_buffer #(
   parameter int BUF_AW = swu_pkg::DEF_BUF_AW
) (
   input  logic             clk,
   input  swu_pkg::buf_wr_t wr_i,
   input  swu_pkg::buf_rd_t rd_i,
   output swu_pkg::word_t   rd_data_o
);
   import swu_pkg::*;

   localparam int DEPTH = 2 ** BUF_AW;

   word_t             mem [DEPTH];
   logic [BUF_AW-1:0] wr_addr;
   logic [BUF_AW-1:0] rd_addr;

   // circular addressing, the index simply wraps on the low bits
   assign wr_addr = wr_i.addr[BUF_AW-1:0];
   assign rd_addr = rd_i.addr[BUF_AW-1:0];

   always_ff @(posedge clk) begin
      if (wr_i.en) begin
         mem[wr_addr] <= wr_i.data;
      end
   end

   // registered read port, data valid the cycle after the request
   always_ff @(posedge clk) begin
      if (rd_i.en) begin
         rd_data_o <= mem[rd_addr];
      end
   end

endmodule

// File: logic/swu_window_walker.sv
`timescale 1ns/1ps

module swu_window_walker #(
   parameter int IFM_DIM    = swu_pkg::DEF_IFM_DIM,
   parameter int KERNEL_DIM = swu_pkg::DEF_KERNEL_DIM,
   parameter int STRIDE     = swu_pkg::DEF_STRIDE,
   parameter int CH_GROUPS  = swu_pkg::DEF_CH_GROUPS
) (
   input  logic                      clk,
   input  logic                      resetn,
   input  logic [swu_pkg::IDX_W-1:0] words_written_i,
   input  logic                      room_i,
   output swu_pkg::buf_rd_t          rd_o,
   output logic [swu_pkg::IDX_W-1:0] window_origin_o,
   output logic                      frame_done_o
);
   import swu_pkg::*;

   localparam int OFM_DIM   = (IFM_DIM - KERNEL_DIM) / STRIDE + 1;
   localparam int ROW_WORDS = IFM_DIM * CH_GROUPS;

   localparam int CH_W = $clog2(CH_GROUPS + 1);
   localparam int K_W  = $clog2(KERNEL_DIM + 1);
   localparam int O_W  = $clog2(OFM_DIM + 1);

   localparam logic [CH_W-1:0] LAST_CH = CH_W'(CH_GROUPS - 1);
   localparam logic [K_W-1:0]  LAST_K  = K_W'(KERNEL_DIM - 1);
   localparam logic [O_W-1:0]  LAST_O  = O_W'(OFM_DIM - 1);

   // index steps in words
   localparam logic [IDX_W-1:0] ROW_STEP = IDX_W'(STRIDE * ROW_WORDS);
   localparam logic [IDX_W-1:0] COL_STEP = IDX_W'(STRIDE * CH_GROUPS);
   localparam logic [IDX_W-1:0] KH_STEP  = IDX_W'(ROW_WORDS);
   localparam logic [IDX_W-1:0] KW_STEP  = IDX_W'(CH_GROUPS);

   logic [CH_W-1:0]  ch_q;
   logic [K_W-1:0]   kw_q;
   logic [K_W-1:0]   kh_q;
   logic [O_W-1:0]   col_q;
   logic [O_W-1:0]   row_q;
   logic [IDX_W-1:0] origin;
   logic [IDX_W-1:0] offset;
   logic [IDX_W-1:0] elem_idx;
   logic             last_ch;
   logic             last_kw;
   logic             last_kh;
   logic             last_col;
   logic             last_row;
   logic             rd_en;

   ////////////////////////////////////////////////////////////////////////////
   // index of the current element
   ////////////////////////////////////////////////////////////////////////////

   // first word of the window
   assign origin = IDX_W'(row_q) * ROW_STEP + IDX_W'(col_q) * COL_STEP;

   // position inside the window
   assign offset = IDX_W'(kh_q) * KH_STEP + IDX_W'(kw_q) * KW_STEP + IDX_W'(ch_q);

   assign elem_idx = origin + offset;

   // only words already in the buffer may be read
   assign rd_en = room_i && (elem_idx < words_written_i);

   always_comb begin
      rd_o.en   = rd_en;
      rd_o.addr = elem_idx;
   end

   assign window_origin_o = origin;

   ////////////////////////////////////////////////////////////////////////////
   // window counters
   ////////////////////////////////////////////////////////////////////////////

   assign last_ch  = ch_q == LAST_CH;
   assign last_kw  = kw_q == LAST_K;
   assign last_kh  = kh_q == LAST_K;
   assign last_col = col_q == LAST_O;
   assign last_row = row_q == LAST_O;

   assign frame_done_o = rd_en && last_ch && last_kw && last_kh && last_col && last_row;

   // channel group innermost, output row outermost
   // all counters wrap to zero together after the last word of the frame
   always_ff @(posedge clk) begin
      if (!resetn) begin
         ch_q  <= '0;
         kw_q  <= '0;
         kh_q  <= '0;
         col_q <= '0;
         row_q <= '0;
      end else if (rd_en) begin
         if (!last_ch) begin
            ch_q <= ch_q + 1'b1;
         end else begin
            ch_q <= '0;
            if (!last_kw) begin
               kw_q <= kw_q + 1'b1;
            end else begin
               kw_q <= '0;
               if (!last_kh) begin
                  kh_q <= kh_q + 1'b1;
               end else begin
                  kh_q <= '0;
                  if (!last_col) begin
                     col_q <= col_q + 1'b1;
                  end else begin
                     col_q <= '0;
                     if (!last_row) begin
                        row_q <= row_q + 1'b1;
                     end else begin
                        row_q <= '0;
                     end
                  end
               end
            end
         end
      end
   end

endmodule

// File: logic/swu_output_stage.sv
`timescale 1ns/1ps

module swu_output_stage (
   input  logic             clk,
   input  logic             resetn,
   input  swu_pkg::buf_rd_t rd_i,
   input  swu_pkg::word_t   rd_data_i,
   output logic             room_o,
   output swu_pkg::word_t   op_tdata_o,
   output logic             op_tvalid_o,
   input  logic             op_tready_i
);
   import swu_pkg::*;

   word_t      entry_q [2];
   logic [1:0] count_q;
   logic       inflight_q;
   logic       push;
   logic       pop;
   logic       push_slot;

   // read issued last cycle, its data sits on rd_data_i now
   always_ff @(posedge clk) begin
      if (!resetn) begin
         inflight_q <= 1'b0;
      end else begin
         inflight_q <= rd_i.en;
      end
   end

   assign push = inflight_q;
   assign pop  = op_tvalid_o && op_tready_i;

   // held words plus the word on its way may not exceed two
   assign room_o = (count_q == 2'd0) || ((count_q == 2'd1) && !inflight_q);

   // entry 0 is the oldest
   assign push_slot = (count_q == 2'd1) && !pop;

   always_ff @(posedge clk) begin
      if (pop) begin
         entry_q[0] <= entry_q[1];
      end
      if (push) begin
         if (push_slot) begin
            entry_q[1] <= rd_data_i;
         end else begin
            entry_q[0] <= rd_data_i;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!resetn) begin
         count_q <= 2'd0;
      end else if (push && !pop) begin
         count_q <= count_q + 2'd1;
      end else if (pop && !push) begin
         count_q <= count_q - 2'd1;
      end
   end

   assign op_tvalid_o = count_q != 2'd0;
   assign op_tdata_o  = entry_q[0];

endmodule

// File: logic/swu_top.sv
`timescale 1ns/1ps

module swu_top #(
   parameter int IFM_DIM    = swu_pkg::DEF_IFM_DIM,
   parameter int KERNEL_DIM = swu_pkg::DEF_KERNEL_DIM,
   parameter int STRIDE     = swu_pkg::DEF_STRIDE,
   parameter int CH_GROUPS  = swu_pkg::DEF_CH_GROUPS,
   parameter int BUF_AW     = swu_pkg::DEF_BUF_AW
) (
   input  logic           clk,
   input  logic           resetn,
   input  swu_pkg::word_t ip_tdata_i,
   input  logic           ip_tvalid_i,
   output logic           ip_tready_o,
   output swu_pkg::word_t op_tdata_o,
   output logic           op_tvalid_o,
   input  logic           op_tready_i
);
   import swu_pkg::*;

   buf_wr_t          wr;
   buf_rd_t          rd;
   word_t            rd_data;
   logic [IDX_W-1:0] words_written;
   logic [IDX_W-1:0] window_origin;
   logic             frame_done;
   logic             room;

   ////////////////////////////////////////////////////////////////////////////
   // input side
   ////////////////////////////////////////////////////////////////////////////

   swu_write_ctrl #(
      .IFM_DIM   (IFM_DIM),
      .CH_GROUPS (CH_GROUPS),
      .BUF_AW    (BUF_AW)
   ) write_ctrl_inst (
      .clk             (clk),
      .resetn          (resetn),
      .ip_tdata_i      (ip_tdata_i),
      .ip_tvalid_i     (ip_tvalid_i),
      .ip_tready_o     (ip_tready_o),
      .window_origin_i (window_origin),
      .frame_done_i    (frame_done),
      .wr_o            (wr),
      .words_written_o (words_written)
   );

   swu_line_buffer #(
      .BUF_AW (BUF_AW)
   ) line_buffer_inst (
      .clk       (clk),
      .wr_i      (wr),
      .rd_i      (rd),
      .rd_data_o (rd_data)
   );

   ////////////////////////////////////////////////////////////////////////////
   // output side
   ////////////////////////////////////////////////////////////////////////////

   swu_window_walker #(
      .IFM_DIM    (IFM_DIM),
      .KERNEL_DIM (KERNEL_DIM),
      .STRIDE     (STRIDE),
      .CH_GROUPS  (CH_GROUPS)
   ) window_walker_inst (
      .clk             (clk),
      .resetn          (resetn),
      .words_written_i (words_written),
      .room_i          (room),
      .rd_o            (rd),
      .window_origin_o (window_origin),
      .frame_done_o    (frame_done)
   );

   swu_output_stage output_stage_inst (
      .clk         (clk),
      .resetn      (resetn),
      .rd_i        (rd),
      .rd_data_i   (rd_data),
      .room_o      (room),
      .op_tdata_o  (op_tdata_o),
      .op_tvalid_o (op_tvalid_o),
      .op_tready_i (op_tready_i)
   );

endmodule

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter int PERIOD_NS    = 10,
   parameter int RESET_CYCLES = 3
) (
   output logic clk_o,
   output logic resetn_o
);

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2) clk_o = ~clk_o;
   end

   // release 1 ns after an edge, in step with the stimulus
   initial begin
      resetn_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      #1;
      resetn_o = 1'b1;
   end

endmodule

// File: testbench/swu_assertions.sv
`timescale 1ns/1ps

module swu_assertions (
   input logic           clk,
   input logic           resetn,
   input swu_pkg::word_t ip_tdata_i,
   input logic           ip_tvalid_i,
   input logic           ip_tready_o,
   input swu_pkg::word_t op_tdata_o,
   input logic           op_tvalid_o,
   input logic           op_tready_i
);

   // a stalled source keeps valid and data until the transfer
   input_held: assert property (@(posedge clk) disable iff (!resetn)
      (ip_tvalid_i && !ip_tready_o) |=> (ip_tvalid_i && $stable(ip_tdata_i)))
      else $error("input stream changed while stalled");

   output_held: assert property (@(posedge clk) disable iff (!resetn)
      (op_tvalid_o && !op_tready_i) |=> (op_tvalid_o && $stable(op_tdata_o)))
      else $error("output stream changed while stalled");

   // queue is empty once reset has been seen at an edge
   reset_quiet: assert property (@(posedge clk)
      !resetn |=> !op_tvalid_o)
      else $error("output valid high during reset");

   ready_after_reset: assert property (@(posedge clk)
      $rose(resetn) |-> ip_tready_o)
      else $error("input not ready right after reset");

endmodule

bind swu_top swu_assertions swu_assertions_inst (
   .clk         (clk),
   .resetn      (resetn),
   .ip_tdata_i  (ip_tdata_i),
   .ip_tvalid_i (ip_tvalid_i),
   .ip_tready_o (ip_tready_o),
   .op_tdata_o  (op_tdata_o),
   .op_tvalid_o (op_tvalid_o),
   .op_tready_i (op_tready_i)
);

// File: testbench/swu_tb.sv
`timescale 1ns/1ps

module swu_tb;
   import swu_pkg::*;

   localparam int OFM_DIM     = (DEF_IFM_DIM - DEF_KERNEL_DIM) / DEF_STRIDE + 1;
   localparam int FRAME_WORDS = DEF_IFM_DIM * DEF_IFM_DIM * DEF_CH_GROUPS;
   localparam int WIN_WORDS   = DEF_KERNEL_DIM * DEF_KERNEL_DIM * DEF_CH_GROUPS;
   localparam int OUT_WORDS   = OFM_DIM * OFM_DIM * WIN_WORDS;
   localparam int DEPTH       = 2 ** DEF_BUF_AW;
   localparam int NUM_ROWS    = 5;
   localparam int TIMEOUT_CYCLES = 20 * NUM_ROWS * (FRAME_WORDS + OUT_WORDS);

   typedef struct packed {
      int in_stall;
      int out_stall;
      int hold;
   } row_t;

   // input stall %, output stall %, cycles of output held off at frame start
   localparam row_t ROWS [NUM_ROWS] = '{
      '{0, 0, 0},
      '{0, 70, 0},
      '{70, 0, 0},
      '{30, 30, 0},
      '{0, 0, 200}
   };

   logic  clk;
   logic  resetn;
   word_t ip_tdata_i;
   logic  ip_tvalid_i;
   logic  ip_tready_o;
   word_t op_tdata_o;
   logic  op_tvalid_o;
   logic  op_tready_i;

   word_t frame_words [FRAME_WORDS];
   word_t expected_q [$];
   int    accepted;

   tb_clock_gen #(
      .PERIOD_NS    (10),
      .RESET_CYCLES (3)
   ) clock_gen_inst (
      .clk_o    (clk),
      .resetn_o (resetn)
   );

   swu_top #(
      .IFM_DIM    (DEF_IFM_DIM),
      .KERNEL_DIM (DEF_KERNEL_DIM),
      .STRIDE     (DEF_STRIDE),
      .CH_GROUPS  (DEF_CH_GROUPS),
      .BUF_AW     (DEF_BUF_AW)
   ) swu_top_inst (
      .clk         (clk),
      .resetn      (resetn),
      .ip_tdata_i  (ip_tdata_i),
      .ip_tvalid_i (ip_tvalid_i),
      .ip_tready_o (ip_tready_o),
      .op_tdata_o  (op_tdata_o),
      .op_tvalid_o (op_tvalid_o),
      .op_tready_i (op_tready_i)
   );

   task automatic check_value(input string what, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         $display("[ERROR] %0t: %s, got %0h expected %0h", $time, what, actual, expected);
         $display("TEST FAILED");
         $fatal(1, "stopping at first mismatch");
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // reference model
   ////////////////////////////////////////////////////////////////////////////

   // fresh frame, then every window word in output row, output column,
   // kernel row, kernel column, channel group order
   task automatic build_frame();
      int idx;
      int col;
      for (int i = 0; i < FRAME_WORDS; i++) begin
         frame_words[i] = word_t'($urandom);
      end
      for (int r = 0; r < OFM_DIM; r++) begin
         for (int c = 0; c < OFM_DIM; c++) begin
            for (int kh = 0; kh < DEF_KERNEL_DIM; kh++) begin
               for (int kw = 0; kw < DEF_KERNEL_DIM; kw++) begin
                  for (int ch = 0; ch < DEF_CH_GROUPS; ch++) begin
                     col = c * DEF_STRIDE + kw;
                     idx = (r * DEF_STRIDE + kh) * DEF_IFM_DIM * DEF_CH_GROUPS
                           + col * DEF_CH_GROUPS + ch;
                     expected_q.push_back(frame_words[idx]);
                  end
               end
            end
         end
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // stream drivers, handshakes sampled mid-cycle
   ////////////////////////////////////////////////////////////////////////////

   task automatic drive_frame(input int stall_pct);
      int   sent;
      logic xfer;
      sent = 0;
      accepted = 0;
      while (sent < FRAME_WORDS) begin
         if (!ip_tvalid_i && int'($urandom_range(99)) >= stall_pct) begin
            ip_tdata_i  = frame_words[sent];
            ip_tvalid_i = 1'b1;
         end
         @(negedge clk);
         xfer = ip_tvalid_i && ip_tready_o;
         @(posedge clk);
         #1;
         if (xfer) begin
            sent++;
            accepted = sent;
            ip_tvalid_i = 1'b0;
         end
      end
   endtask

   task automatic collect_frame(input int stall_pct, input int hold);
      int    got;
      word_t exp_w;
      got = 0;
      op_tready_i = 1'b0;
      if (hold > 0) begin
         repeat (hold) @(posedge clk);
         #1;
         @(negedge clk);
         // window origin is still 0, so the buffer holds exactly DEPTH words
         check_value("input ready while output held", 32'(ip_tready_o), 32'd0);
         check_value("words buffered ahead of window", 32'(accepted), 32'(DEPTH));
         @(posedge clk);
         #1;
      end
      while (got < OUT_WORDS) begin
         op_tready_i = int'($urandom_range(99)) >= stall_pct;
         @(negedge clk);
         if (op_tvalid_o && op_tready_i) begin
            exp_w = expected_q.pop_front();
            check_value("output word", 32'(op_tdata_o), 32'(exp_w));
            got++;
         end
         @(posedge clk);
         #1;
      end
      op_tready_i = 1'b0;
   endtask

   initial begin
      row_t row;
      int   seed_ret;
      ip_tdata_i  = '0;
      ip_tvalid_i = 1'b0;
      op_tready_i = 1'b0;
      accepted    = 0;
      seed_ret    = $urandom(32'h815a23ad);

      @(posedge resetn);
      @(negedge clk);
      check_value("input ready after reset", 32'(ip_tready_o), 32'd1);
      check_value("output valid after reset", 32'(op_tvalid_o), 32'd0);
      @(posedge clk);
      #1;

      // frames run back to back, no reset in between
      for (int i = 0; i < NUM_ROWS; i++) begin
         row = ROWS[i];
         build_frame();
         fork
            drive_frame(row.in_stall);
            collect_frame(row.out_stall, row.hold);
         join
      end

      // nothing beyond the last window word
      op_tready_i = 1'b1;
      repeat (20) begin
         @(negedge clk);
         check_value("extra output word", 32'(op_tvalid_o), 32'd0);
      end

      $display("TEST PASSED");
      $finish;
   end

   initial begin
      repeat (TIMEOUT_CYCLES) @(posedge clk);
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $fatal(1, "watchdog expired");
   end

endmodule

// File: sim.f
logic/swu_pkg.sv
logic/swu_write_ctrl.sv
logic/swu_line_buffer.sv
logic/swu_window_walker.sv
logic/swu_output_stage.sv
logic/swu_top.sv
testbench/tb_clock_gen.sv
testbench/swu_assertions.sv
testbench/swu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator and run it, exit status is the result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module swu_tb -f sim.f -o swu_sim \
   && ./obj_dir/swu_sim \
   || { echo "simulation failed"; exit 1; }
